// ==== hw/clockPkg.sv ====
`default_nettype none

package clockPkg;

    localparam int DIGIT_COUNT = 6;
    localparam int BCD_WIDTH   = 4;

    // digit limits for wrap and carry
    localparam logic [BCD_WIDTH-1:0] ONES_MAX = 4'd9;
    localparam logic [BCD_WIDTH-1:0] TENS_MAX = 4'd5;
    localparam logic [5:0] HOURS_PER_DAY = 6'd24;
    localparam logic [4:0] PM_HOUR = 5'd12;

    // index 0 is seconds ones, index 5 is hours tens
    typedef logic [2:0] digitIdx_t;

    typedef struct packed {
        logic [BCD_WIDTH-1:0] hrsTens;
        logic [BCD_WIDTH-1:0] hrsOnes;
        logic [BCD_WIDTH-1:0] minTens;
        logic [BCD_WIDTH-1:0] minOnes;
        logic [BCD_WIDTH-1:0] secTens;
        logic [BCD_WIDTH-1:0] secOnes;
    } timeFields_t;

    // same 24 bits, seen as named fields or as a digit array
    typedef union packed {
        timeFields_t fields;
        logic [DIGIT_COUNT-1:0][BCD_WIDTH-1:0] digits;
    } clockTime_u;

    // active low, gfedcba
    localparam logic [6:0] SEG_PATTERNS [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

endpackage

`default_nettype wire

// ==== hw/digitAdjustIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface digitAdjustIf
    import clockPkg::*;
();

    logic      inc;
    logic      dec;
    digitIdx_t digitSel;
    // level, counting is suspended while high
    logic      hold;

    modport ctrl (output inc, output dec, output digitSel, output hold);
    modport counter (input inc, input dec, input digitSel, input hold);

endinterface

`default_nettype wire

// ==== hw/bcdTimeCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcdTimeCounter
    import clockPkg::*;
#(
    parameter bit COUNTING         = 1'b1,
    parameter int TICKS_PER_SECOND = 100000000
) (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    digitAdjustIf.counter        adj,
    output clockTime_u           o_Time
);

    clockTime_u           timeQ;
    clockTime_u           nextTime;
    logic                 secTick;
    logic [5:0]           hourNow;
    logic [5:0]           hourNext;
    logic [BCD_WIDTH-1:0] hrsTensNext;

    // single digit step, wraps inside 0..maxVal with no carry
    function automatic logic [BCD_WIDTH-1:0] wrapDigit(input logic [BCD_WIDTH-1:0] d,
                                                        input logic [BCD_WIDTH-1:0] maxVal,
                                                        input logic up);
        if (up) begin
            return (d >= maxVal) ? '0 : d + 1'b1;
        end
        return (d == '0) ? maxVal : d - 1'b1;
    endfunction

    // hour value step modulo 24
    function automatic logic [5:0] stepHour(input logic [5:0] hour, input logic up,
                                            input logic [5:0] amount);
        logic [5:0] sum;
        sum = hour + amount;
        if (up) begin
            return (sum >= HOURS_PER_DAY) ? sum - HOURS_PER_DAY : sum;
        end
        return (hour < amount) ? hour + HOURS_PER_DAY - amount : hour - amount;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // one second tick
    //////////////////////////////////////////////////////////////////////
    if (COUNTING) begin : genTick
        localparam int TICK_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;

        logic [TICK_W-1:0] tickCnt;
        logic              tickLast;

        assign tickLast = (tickCnt == TICK_W'(TICKS_PER_SECOND - 1));

        // tick count is frozen while editing
        always_ff @(posedge i_Clk or negedge i_rstN) begin
            if (!i_rstN) begin
                tickCnt <= '0;
            end else if (!adj.hold) begin
                tickCnt <= tickLast ? '0 : tickCnt + 1'b1;
            end
        end

        assign secTick = tickLast && !adj.hold;
    end else begin : genNoTick
        assign secTick = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // next word
    //////////////////////////////////////////////////////////////////////
    assign hourNow = 6'(timeQ.fields.hrsTens) * 6'd10 + 6'(timeQ.fields.hrsOnes);

    always_comb begin
        nextTime = timeQ;
        hourNext = hourNow;
        if (adj.inc || adj.dec) begin
            case (adj.digitSel)
                3'd0: nextTime.fields.secOnes = wrapDigit(timeQ.fields.secOnes, ONES_MAX, adj.inc);
                3'd1: nextTime.fields.secTens = wrapDigit(timeQ.fields.secTens, TENS_MAX, adj.inc);
                3'd2: nextTime.fields.minOnes = wrapDigit(timeQ.fields.minOnes, ONES_MAX, adj.inc);
                3'd3: nextTime.fields.minTens = wrapDigit(timeQ.fields.minTens, TENS_MAX, adj.inc);
                3'd4: hourNext = stepHour(hourNow, adj.inc, 6'd1);
                3'd5: hourNext = stepHour(hourNow, adj.inc, 6'd10);
                default: ;
            endcase
        end else if (secTick) begin
            // ripple carry, seconds up into hours
            nextTime.fields.secOnes = wrapDigit(timeQ.fields.secOnes, ONES_MAX, 1'b1);
            if (timeQ.fields.secOnes == ONES_MAX) begin
                nextTime.fields.secTens = wrapDigit(timeQ.fields.secTens, TENS_MAX, 1'b1);
                if (timeQ.fields.secTens == TENS_MAX) begin
                    nextTime.fields.minOnes = wrapDigit(timeQ.fields.minOnes, ONES_MAX, 1'b1);
                    if (timeQ.fields.minOnes == ONES_MAX) begin
                        nextTime.fields.minTens = wrapDigit(timeQ.fields.minTens, TENS_MAX,
                                                            1'b1);
                        if (timeQ.fields.minTens == TENS_MAX) begin
                            hourNext = stepHour(hourNow, 1'b1, 6'd1);
                        end
                    end
                end
            end
        end
        // back to BCD
        hrsTensNext = (hourNext >= 6'd20) ? 4'd2 : ((hourNext >= 6'd10) ? 4'd1 : 4'd0);
        nextTime.fields.hrsTens = hrsTensNext;
        nextTime.fields.hrsOnes = 4'(hourNext - 6'(hrsTensNext) * 6'd10);
    end

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            timeQ <= '0;
        end else begin
            timeQ <= nextTime;
        end
    end

    assign o_Time = timeQ;

endmodule

`default_nettype wire

// ==== hw/editControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module editControl
    import clockPkg::*;
(
    input  logic       i_Clk,
    input  logic       i_rstN,
    input  logic       i_Encoder_Enable,
    input  logic       i_Change_Alarm,
    input  logic       i_Change_Mode,
    input  logic       i_Step_Up,
    input  logic       i_Step_Down,
    digitAdjustIf.ctrl timeAdj,
    digitAdjustIf.ctrl alarmAdj,
    output logic       o_Show_Alarm
);

    digitIdx_t digitSel;
    logic      stepUp;
    logic      stepDown;

    // step strobes only count while editing
    assign stepUp   = i_Step_Up && i_Encoder_Enable;
    assign stepDown = i_Step_Down && i_Encoder_Enable;

    // selection walks hours tens down to seconds ones, then wraps
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            digitSel <= digitIdx_t'(DIGIT_COUNT - 1);
        end else if (i_Change_Mode && i_Encoder_Enable) begin
            if (digitSel == '0) begin
                digitSel <= digitIdx_t'(DIGIT_COUNT - 1);
            end else begin
                digitSel <= digitSel - 1'b1;
            end
        end
    end

    // each strobe goes to exactly one word
    assign timeAdj.inc       = stepUp && !i_Change_Alarm;
    assign timeAdj.dec       = stepDown && !i_Change_Alarm;
    assign alarmAdj.inc      = stepUp && i_Change_Alarm;
    assign alarmAdj.dec      = stepDown && i_Change_Alarm;
    assign timeAdj.digitSel  = digitSel;
    assign alarmAdj.digitSel = digitSel;

    // clock stops while editing, alarm word never runs
    assign timeAdj.hold  = i_Encoder_Enable;
    assign alarmAdj.hold = 1'b1;

    assign o_Show_Alarm = i_Change_Alarm;

endmodule

`default_nettype wire

// ==== hw/alarmMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module alarmMonitor
    import clockPkg::*;
(
    input  logic       i_Clk,
    input  logic       i_rstN,
    input  logic       i_Alarm_Enable,
    input  clockTime_u i_Time,
    input  clockTime_u i_Alarm_Time,
    output logic       o_Alarm_On
);

    logic [DIGIT_COUNT-1:0] digitMatch;

    // per digit compare
    always_comb begin
        for (int i = 0; i < DIGIT_COUNT; i++) begin
            digitMatch[i] = (i_Time.digits[i] == i_Alarm_Time.digits[i]);
        end
    end

    // latch holds until the enable drops
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_Alarm_On <= 1'b0;
        end else if (!i_Alarm_Enable) begin
            o_Alarm_On <= 1'b0;
        end else if (&digitMatch) begin
            o_Alarm_On <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/segmentDriver.sv ====
`timescale 1ns/1ps
`default_nettype none

module segmentDriver
    import clockPkg::*;
#(
    parameter int SCAN_TICKS = 12500
) (
    input  logic                   i_Clk,
    input  logic                   i_rstN,
    input  logic                   i_Show_Alarm,
    input  clockTime_u             i_Time,
    input  clockTime_u             i_Alarm_Time,
    output logic [6:0]             o_Segments,
    output logic [DIGIT_COUNT-1:0] o_Anodes,
    output logic                   o_PM
);

    localparam int SCAN_W = (SCAN_TICKS > 1) ? $clog2(SCAN_TICKS) : 1;

    logic [SCAN_W-1:0]    scanCnt;
    logic                 scanStep;
    digitIdx_t            scanIdx;
    clockTime_u           shownTime;
    logic [BCD_WIDTH-1:0] shownDigit;
    logic [4:0]           shownHour;

    //////////////////////////////////////////////////////////////////////
    // digit scan
    //////////////////////////////////////////////////////////////////////
    assign scanStep = (scanCnt == SCAN_W'(SCAN_TICKS - 1));

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            scanCnt <= '0;
            scanIdx <= '0;
        end else begin
            scanCnt <= scanStep ? '0 : scanCnt + 1'b1;
            if (scanStep) begin
                if (scanIdx == digitIdx_t'(DIGIT_COUNT - 1)) begin
                    scanIdx <= '0;
                end else begin
                    scanIdx <= scanIdx + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode and output registers
    //////////////////////////////////////////////////////////////////////
    assign shownTime  = i_Show_Alarm ? i_Alarm_Time : i_Time;
    assign shownDigit = shownTime.digits[scanIdx];
    assign shownHour  = 5'(shownTime.digits[5]) * 5'd10 + 5'(shownTime.digits[4]);

    // segments, anodes and PM move together
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_Segments <= SEG_PATTERNS[0];
            o_Anodes   <= ~DIGIT_COUNT'(1);
            o_PM       <= 1'b0;
        end else begin
            // blank on a non-BCD value
            o_Segments <= (shownDigit > ONES_MAX) ? 7'h7F : SEG_PATTERNS[shownDigit];
            o_Anodes   <= ~(DIGIT_COUNT'(1) << scanIdx);
            o_PM       <= (shownHour >= PM_HOUR);
        end
    end

endmodule

`default_nettype wire

// ==== hw/alarmClockTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module alarmClockTop
    import clockPkg::*;
#(
    parameter int TICKS_PER_SECOND = 100000000,
    parameter int SCAN_TICKS       = 12500
) (
    input  logic                   i_Clk,
    input  logic                   i_rstN,
    input  logic                   i_Encoder_Enable,
    input  logic                   i_Change_Alarm,
    input  logic                   i_Change_Mode,
    input  logic                   i_Step_Up,
    input  logic                   i_Step_Down,
    input  logic                   i_Alarm_Enable,
    output logic [6:0]             o_Segments,
    output logic [DIGIT_COUNT-1:0] o_Anodes,
    output logic                   o_PM,
    output logic                   o_Alarm_On
);

    //////////////////////////////////////////////////////////////////////
    // edit path
    //////////////////////////////////////////////////////////////////////
    digitAdjustIf timeAdj ();
    digitAdjustIf alarmAdj ();

    logic showAlarm;

    editControl u_editControl (
        .i_Clk            (i_Clk),
        .i_rstN           (i_rstN),
        .i_Encoder_Enable (i_Encoder_Enable),
        .i_Change_Alarm   (i_Change_Alarm),
        .i_Change_Mode    (i_Change_Mode),
        .i_Step_Up        (i_Step_Up),
        .i_Step_Down      (i_Step_Down),
        .timeAdj          (timeAdj),
        .alarmAdj         (alarmAdj),
        .o_Show_Alarm     (showAlarm)
    );

    //////////////////////////////////////////////////////////////////////
    // time and alarm words
    //////////////////////////////////////////////////////////////////////
    clockTime_u timeWord;
    clockTime_u alarmWord;

    bcdTimeCounter #(
        .COUNTING         (1'b1),
        .TICKS_PER_SECOND (TICKS_PER_SECOND)
    ) u_timeCounter (
        .i_Clk  (i_Clk),
        .i_rstN (i_rstN),
        .adj    (timeAdj),
        .o_Time (timeWord)
    );

    // alarm word never counts, it only takes edits
    bcdTimeCounter #(
        .COUNTING         (1'b0),
        .TICKS_PER_SECOND (TICKS_PER_SECOND)
    ) u_alarmCounter (
        .i_Clk  (i_Clk),
        .i_rstN (i_rstN),
        .adj    (alarmAdj),
        .o_Time (alarmWord)
    );

    //////////////////////////////////////////////////////////////////////
    // alarm and display
    //////////////////////////////////////////////////////////////////////
    alarmMonitor u_alarmMonitor (
        .i_Clk          (i_Clk),
        .i_rstN         (i_rstN),
        .i_Alarm_Enable (i_Alarm_Enable),
        .i_Time         (timeWord),
        .i_Alarm_Time   (alarmWord),
        .o_Alarm_On     (o_Alarm_On)
    );

    segmentDriver #(
        .SCAN_TICKS (SCAN_TICKS)
    ) u_segmentDriver (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_Show_Alarm (showAlarm),
        .i_Time       (timeWord),
        .i_Alarm_Time (alarmWord),
        .o_Segments   (o_Segments),
        .o_Anodes     (o_Anodes),
        .o_PM         (o_PM)
    );

endmodule

`default_nettype wire

// ==== sim/alarmClockTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alarmClockTb
    import clockPkg::*;
;

    localparam int CLK_PERIOD      = 8;
    localparam int TICKS           = 4;
    localparam int SCAN            = 3;
    localparam int EDIT_BURSTS     = 6;
    localparam int BURST_LEN       = 200;
    localparam int COUNT_RUNS      = 3;
    localparam int PM_RUNS         = 4;
    localparam int ALARM_RUNS      = 4;
    localparam int NUM_TESTS       = 1 + EDIT_BURSTS + COUNT_RUNS + PM_RUNS + ALARM_RUNS;
    localparam int CYCLES_PER_TEST = 3000;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

    logic                   clk;
    logic                   rstN;
    logic                   encoderEnable;
    logic                   changeAlarm;
    logic                   changeMode;
    logic                   stepUp;
    logic                   stepDown;
    logic                   alarmEnable;
    logic [6:0]             segments;
    logic [DIGIT_COUNT-1:0] anodes;
    logic                   pm;
    logic                   alarmOn;

    // reference model, word 0 is the time and word 1 the alarm
    int mWord [2][DIGIT_COUNT];
    int mSel;
    int mTick;
    bit mAlarmOn;

    // expected patterns, active low gfedcba
    logic [6:0] segTable [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

    alarmClockTop #(
        .TICKS_PER_SECOND (TICKS),
        .SCAN_TICKS       (SCAN)
    ) i_alarmClockTop (
        .i_Clk            (clk),
        .i_rstN           (rstN),
        .i_Encoder_Enable (encoderEnable),
        .i_Change_Alarm   (changeAlarm),
        .i_Change_Mode    (changeMode),
        .i_Step_Up        (stepUp),
        .i_Step_Down      (stepDown),
        .i_Alarm_Enable   (alarmEnable),
        .o_Segments       (segments),
        .o_Anodes         (anodes),
        .o_PM             (pm),
        .o_Alarm_On       (alarmOn)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test failures found");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // model helpers
    //////////////////////////////////////////////////////////////////////
    function automatic int hourOf(input int w);
        return mWord[w][5] * 10 + mWord[w][4];
    endfunction

    function automatic int secondsOf(input int w);
        return hourOf(w) * 3600 + (mWord[w][3] * 10 + mWord[w][2]) * 60
               + mWord[w][1] * 10 + mWord[w][0];
    endfunction

    function automatic void loadSeconds(input int w, input int total);
        int s;
        s = total % 86400;
        mWord[w][5] = s / 36000;
        mWord[w][4] = (s / 3600) % 10;
        mWord[w][3] = (s % 3600) / 600;
        mWord[w][2] = (s / 60) % 10;
        mWord[w][1] = (s % 60) / 10;
        mWord[w][0] = s % 10;
    endfunction

    // hours move as one value, other digits wrap alone
    function automatic void stepDigit(input int w, input int idx, input bit up);
        int amount;
        int hour;
        int maxVal;
        int d;
        if (idx >= 4) begin
            amount = (idx == 4) ? 1 : 10;
            hour = (hourOf(w) + (up ? amount : 24 - amount)) % 24;
            mWord[w][5] = hour / 10;
            mWord[w][4] = hour % 10;
        end else begin
            maxVal = (idx % 2 == 1) ? 5 : 9;
            d = mWord[w][idx];
            mWord[w][idx] = up ? ((d == maxVal) ? 0 : d + 1) : ((d == 0) ? maxVal : d - 1);
        end
    endfunction

    function automatic int decodeSegments(input logic [6:0] seg);
        for (int i = 0; i < 10; i++) begin
            if (segTable[i] === seg) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one clock with model update, alarm output checked every cycle
    //////////////////////////////////////////////////////////////////////
    task automatic stepClock();
        int w;
        w = changeAlarm ? 1 : 0;
        // latch compares the words from before the edge
        if (!alarmEnable) begin
            mAlarmOn = 1'b0;
        end else if (secondsOf(0) == secondsOf(1)) begin
            mAlarmOn = 1'b1;
        end
        if (encoderEnable) begin
            if (stepUp || stepDown) begin
                stepDigit(w, mSel, stepUp);
            end
            if (changeMode) begin
                mSel = (mSel == 0) ? DIGIT_COUNT - 1 : mSel - 1;
            end
        end else if (mTick == TICKS - 1) begin
            mTick = 0;
            loadSeconds(0, secondsOf(0) + 1);
        end else begin
            mTick++;
        end
        @(posedge clk);
        #1;
        checkValue("o_Alarm_On", alarmOn, mAlarmOn);
    endtask

    // kind 0 is mode, 1 is up, 2 is down
    task automatic strobeInput(input int kind);
        changeMode = (kind == 0);
        stepUp     = (kind == 1);
        stepDown   = (kind == 2);
        stepClock();
        changeMode = 1'b0;
        stepUp     = 1'b0;
        stepDown   = 1'b0;
        stepClock();
    endtask

    task automatic setWord(input int w, input int total);
        int want[DIGIT_COUNT];
        want[0] = total % 10;
        want[1] = (total % 60) / 10;
        want[2] = (total / 60) % 10;
        want[3] = (total % 3600) / 600;
        encoderEnable = 1'b1;
        changeAlarm   = (w == 1);
        for (int idx = 4; idx >= 0; idx--) begin
            while (mSel != idx) begin
                strobeInput(0);
            end
            // hour ones covers the whole hour value
            while ((idx == 4) ? (hourOf(w) != total / 3600) : (mWord[w][idx] != want[idx])) begin
                strobeInput(1);
            end
        end
    endtask

    task automatic checkDisplay(input bit showAlarm);
        bit seen[DIGIT_COUNT];
        int seenCount;
        int cycles;
        int idx;
        int w;
        w = showAlarm ? 1 : 0;
        seenCount = 0;
        cycles = 0;
        for (int i = 0; i < DIGIT_COUNT; i++) begin
            seen[i] = 1'b0;
        end
        encoderEnable = 1'b1;
        changeAlarm   = showAlarm;
        // outputs follow the select one cycle later
        stepClock();
        while (seenCount < DIGIT_COUNT && cycles < 4 * DIGIT_COUNT * SCAN) begin
            checkValue("o_Anodes low count", $countones(~anodes), 1);
            idx = 0;
            for (int i = 0; i < DIGIT_COUNT; i++) begin
                if (!anodes[i]) begin
                    idx = i;
                end
            end
            checkValue($sformatf("o_Segments digit %0d", idx), decodeSegments(segments),
                       mWord[w][idx]);
            checkValue("o_PM", pm, hourOf(w) >= 12);
            if (!seen[idx]) begin
                seen[idx] = 1'b1;
                seenCount++;
            end
            stepClock();
            cycles++;
        end
        if (seenCount < DIGIT_COUNT) begin
            $display("Display scan did not reach all %0d digits", DIGIT_COUNT);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hcbae_e95e));
        rstN          = 1'b0;
        encoderEnable = 1'b1;
        changeAlarm   = 1'b0;
        changeMode    = 1'b0;
        stepUp        = 1'b0;
        stepDown      = 1'b0;
        alarmEnable   = 1'b0;
        for (int w = 0; w < 2; w++) begin
            loadSeconds(w, 0);
        end
        mSel     = DIGIT_COUNT - 1;
        mTick    = 0;
        mAlarmOn = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;

        // reset state, words frozen
        checkDisplay(1'b0);
        checkDisplay(1'b1);

        // random edit bursts
        for (int b = 0; b < EDIT_BURSTS; b++) begin
            for (int n = 0; n < BURST_LEN; n++) begin
                changeAlarm = 1'($urandom_range(0, 1));
                strobeInput(int'($urandom_range(0, 2)));
            end
            checkDisplay(1'b0);
            checkDisplay(1'b1);
        end

        // counting through midnight
        for (int r = 0; r < COUNT_RUNS; r++) begin
            setWord(0, 23 * 3600 + 59 * 60 + 50);
            changeAlarm   = 1'b0;
            encoderEnable = 1'b0;
            repeat (int'($urandom_range(10, 30)) * TICKS) stepClock();
            checkDisplay(1'b0);
        end

        // PM flag on random words
        for (int r = 0; r < PM_RUNS; r++) begin
            setWord(0, int'($urandom_range(0, 86399)));
            setWord(1, int'($urandom_range(0, 86399)));
            checkDisplay(1'b0);
            checkDisplay(1'b1);
        end

        // alarm match, clear, and a match while disabled
        for (int r = 0; r < ALARM_RUNS; r++) begin
            setWord(0, int'($urandom_range(0, 86399)));
            setWord(1, (secondsOf(0) + int'($urandom_range(1, 8))) % 86400);
            alarmEnable   = 1'b1;
            changeAlarm   = 1'b0;
            encoderEnable = 1'b0;
            repeat (10 * TICKS) stepClock();
            checkValue("o_Alarm_On", alarmOn, 1);
            alarmEnable = 1'b0;
            stepClock();
            setWord(1, (secondsOf(0) + int'($urandom_range(1, 8))) % 86400);
            changeAlarm   = 1'b0;
            encoderEnable = 1'b0;
            repeat (10 * TICKS) stepClock();
            checkValue("o_Alarm_On", alarmOn, 0);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/clockPkg.sv
hw/digitAdjustIf.sv
hw/bcdTimeCounter.sv
hw/editControl.sv
hw/alarmMonitor.sv
hw/segmentDriver.sv
hw/alarmClockTop.sv
sim/alarmClockTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module alarmClockTb -f vlog.f -Mdir obj_dir
	./obj_dir/ValarmClockTb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
